//--- project.f
hdl/maxpool_pkg.sv
hdl/line_window.sv
hdl/column_max.sv
hdl/pool_position.sv
hdl/pool_combine.sv
hdl/maxpool_3x3.sv
dv/maxpool_3x3_properties.sv
dv/maxpool_3x3_tb.sv

//--- Bender.yml
package:
  name: maxpool_3x3

sources:
  # RTL
  - files:
      - hdl/maxpool_pkg.sv
      - hdl/line_window.sv
      - hdl/column_max.sv
      - hdl/pool_position.sv
      - hdl/pool_combine.sv
      - hdl/maxpool_3x3.sv

  # Testbench
  - target: test
    files:
      - dv/maxpool_3x3_properties.sv
      - dv/maxpool_3x3_tb.sv

//--- dv/maxpool_3x3_tb.sv
`timescale 1ns/1ps

module maxpool_3x3_tb;

	import maxpool_pkg::*;

	localparam int NUM_FRAMES  = 15;
	localparam int CYCLE_LIMIT = NUM_FRAMES * IMG_W * IMG_H * 3 + 200;
	localparam int DRAIN_LIMIT = 20;
	localparam int FRAME_PIX   = IMG_W * IMG_H;

	typedef struct packed {
		pixel_t pxl;
		logic   last;
	} expect_t;

	logic   clk;
	logic   reset;
	logic   valid_in;
	pixel_t pxl_in;
	pixel_t pxl_out;
	logic   valid_out;
	logic   frame_done;

	pixel_t  frame [IMG_H][IMG_W];
	expect_t expq [$];

	int   errors      = 0;
	int   err_mark    = 0;
	int   tests_clean = 0;
	int   tests_bad   = 0;
	int   cycles      = 0;
	logic ignore_out  = 1'b0;

	maxpool_3x3 uut (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.pxl_in     (pxl_in),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

	bind maxpool_3x3 maxpool_3x3_properties props (
		.clk        (clk),
		.reset      (reset),
		.valid_in   (valid_in),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display("Testbench failed");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Output checks
	//////////////////////////////////////////////////

	always @(negedge clk) begin : check_out
		expect_t e;
		if (valid_out && !ignore_out) begin
			if (expq.size() == 0) begin
				$display("Extra output pixel %h arrived with none expected", pxl_out);
				errors++;
			end else begin
				e = expq.pop_front();
				assert (pxl_out == e.pxl)
				else begin
					$display("Fail: pxl_out expected %h actual %h", e.pxl, pxl_out);
					errors++;
				end
				assert (frame_done == e.last)
				else begin
					$display("Fail: frame_done expected %h actual %h", e.last, frame_done);
					errors++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Frames and reference model
	//////////////////////////////////////////////////

	task automatic fill_ramp();
		for (int r = 0; r < IMG_H; r++)
			for (int c = 0; c < IMG_W; c++)
				frame[r][c] = pixel_t'(r * IMG_W + c);
	endtask

	task automatic fill_random(input int max_val);
		for (int r = 0; r < IMG_H; r++)
			for (int c = 0; c < IMG_W; c++)
				frame[r][c] = pixel_t'($urandom_range(0, max_val));
	endtask

	task automatic fill_const(input pixel_t v);
		for (int r = 0; r < IMG_H; r++)
			for (int c = 0; c < IMG_W; c++)
				frame[r][c] = v;
	endtask

	// 3x3 window centred on each even row and column without padding
	task automatic queue_expected();
		expect_t e;
		pixel_t  m;
		int      r;
		int      c;
		for (int oi = 0; oi < IMG_H / 2; oi++) begin
			for (int oj = 0; oj < IMG_W / 2; oj++) begin
				m = '0;
				for (int dr = -1; dr <= 1; dr++) begin
					for (int dc = -1; dc <= 1; dc++) begin
						r = 2 * oi + dr;
						c = 2 * oj + dc;
						if (r >= 0 && r < IMG_H && c >= 0 && c < IMG_W) begin
							if (frame[r][c] > m)
								m = frame[r][c];
						end
					end
				end
				e.pxl  = m;
				e.last = (oi == IMG_H / 2 - 1) && (oj == IMG_W / 2 - 1);
				expq.push_back(e);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus
	//////////////////////////////////////////////////

	// Raster order with optional random idle cycles after each pixel
	task automatic drive_frame(input int gap_max, input int npix);
		int gap;
		for (int k = 0; k < npix; k++) begin
			@(posedge clk);
			#1;
			valid_in = 1'b1;
			pxl_in   = frame[k / IMG_W][k % IMG_W];
			gap      = (gap_max > 0) ? $urandom_range(0, gap_max) : 0;
			repeat (gap) begin
				@(posedge clk);
				#1;
				valid_in = 1'b0;
			end
		end
	endtask

	task automatic go_idle();
		@(posedge clk);
		#1;
		valid_in = 1'b0;
	endtask

	task automatic pulse_reset(input int n);
		@(posedge clk);
		#1;
		reset = 1'b1;
		repeat (n) @(posedge clk);
		#1;
		reset = 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		while (expq.size() != 0 && waited < DRAIN_LIMIT) begin
			@(posedge clk);
			waited++;
		end
		if (expq.size() != 0) begin
			$display("%0d expected output pixels never appeared", expq.size());
			errors++;
			expq.delete();
		end
		// Room for a stray output to show up
		repeat (4) @(posedge clk);
	endtask

	task automatic finish_test(input string name);
		int now_err;
		now_err = errors + int'(uut.props.fail_cnt);
		if (now_err == err_mark) begin
			$display("%s: no errors", name);
			tests_clean++;
		end else begin
			$display("%s: %0d errors", name, now_err - err_mark);
			tests_bad++;
		end
		err_mark = now_err;
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////

	initial begin
		void'($urandom(32'h0d35_8012));
		reset    = 1'b1;
		valid_in = 1'b0;
		pxl_in   = '0;
		repeat (16) @(posedge clk);
		#1;
		reset = 1'b0;

		fill_ramp();
		queue_expected();
		drive_frame(0, FRAME_PIX);
		go_idle();
		wait_drain();
		finish_test("test 1 ramp frame");

		fill_random(255);
		queue_expected();
		drive_frame(2, FRAME_PIX);
		go_idle();
		wait_drain();
		finish_test("test 2 random frame with gaps");

		// Bright frame first, so any stale row or column would show
		fill_const(8'hFF);
		queue_expected();
		drive_frame(0, FRAME_PIX);
		fill_random(8'h1F);
		queue_expected();
		drive_frame(0, FRAME_PIX);
		go_idle();
		wait_drain();
		finish_test("test 3 back-to-back frames");

		ignore_out = 1'b1;
		fill_random(255);
		// Stop on a closing pixel so its output is still in flight at reset
		drive_frame(0, 5 * IMG_W + 4);
		go_idle();
		pulse_reset(8);
		ignore_out = 1'b0;
		fill_random(255);
		queue_expected();
		drive_frame(1, FRAME_PIX);
		go_idle();
		wait_drain();
		finish_test("test 4 reset mid-frame");

		for (int k = 0; k < 9; k++) begin
			fill_random(8'hFE);
			frame[3 + k / 3][3 + k % 3] = 8'hFF;
			queue_expected();
			drive_frame(0, FRAME_PIX);
		end
		go_idle();
		wait_drain();
		finish_test("test 5 peak at each window slot");

		$display("Summary: %0d tests clean, %0d tests with errors", tests_clean, tests_bad);
		if (tests_bad == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

//--- dv/maxpool_3x3_properties.sv
`timescale 1ns/1ps

module maxpool_3x3_properties (
	input logic clk,
	input logic reset,
	input logic valid_in,
	input logic valid_out,
	input logic frame_done
);

	import maxpool_pkg::*;

	// Number of failed assertions so far
	int unsigned fail_cnt = 0;

	logic [COL_CNT_W-1:0] in_col;
	logic [ROW_CNT_W-1:0] in_row;
	logic                 odd_pixel;
	int unsigned          out_cnt;

	//////////////////////////////////////////////////
	// Input position and output count
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			in_col <= '0;
			in_row <= '0;
		end else if (valid_in) begin
			if (in_col == COL_CNT_W'(IMG_W - 1)) begin
				in_col <= '0;
				in_row <= (in_row == ROW_CNT_W'(IMG_H - 1)) ? '0 : in_row + 1'b1;
			end else begin
				in_col <= in_col + 1'b1;
			end
		end
	end

	// Pixel that closes a pooling window
	assign odd_pixel = valid_in & in_col[0] & in_row[0];

	// Outputs seen so far in the current frame
	always_ff @(posedge clk) begin
		if (reset) begin
			out_cnt <= 0;
		end else if (valid_out) begin
			out_cnt <= frame_done ? 0 : out_cnt + 1;
		end
	end

	//////////////////////////////////////////////////
	// Assertions
	//////////////////////////////////////////////////

	a_quiet_in_reset: assert property (@(posedge clk) reset |=> !valid_out)
		else begin
			$error("valid_out was high while reset was asserted");
			fail_cnt++;
		end

	a_quiet_after_reset: assert property (
		@(posedge clk) $fell(reset) |-> !valid_out ##1 !valid_out)
		else begin
			$error("valid_out was high right after reset");
			fail_cnt++;
		end

	a_latency: assert property (
		@(posedge clk) disable iff (reset) odd_pixel |-> ##3 valid_out)
		else begin
			$error("valid_out missing three cycles after an odd row and column pixel");
			fail_cnt++;
		end

	a_no_spurious: assert property (
		@(posedge clk) disable iff (reset) valid_out |-> $past(odd_pixel, 3))
		else begin
			$error("valid_out without a closing pixel three cycles earlier");
			fail_cnt++;
		end

	a_done_with_valid: assert property (
		@(posedge clk) disable iff (reset) frame_done |-> valid_out)
		else begin
			$error("frame_done without valid_out");
			fail_cnt++;
		end

	a_done_count: assert property (
		@(posedge clk) disable iff (reset) frame_done |-> out_cnt == OUT_PER_FRAME - 1)
		else begin
			$error("frame_done before the full frame of outputs");
			fail_cnt++;
		end

	a_done_at_end: assert property (
		@(posedge clk) disable iff (reset)
		(valid_out && out_cnt == OUT_PER_FRAME - 1) |-> frame_done)
		else begin
			$error("frame_done missing on the last output of a frame");
			fail_cnt++;
		end

endmodule

//--- hdl/maxpool_3x3.sv
`timescale 1ns/1ps

module maxpool_3x3 (
	input  logic                clk,
	input  logic                reset,
	input  logic                valid_in,
	input  maxpool_pkg::pixel_t pxl_in,
	output maxpool_pkg::pixel_t pxl_out,
	output logic                valid_out,
	output logic                frame_done
);

	import maxpool_pkg::*;

	logic       col_valid;
	column_t    col;
	logic       mask_top;
	logic       cmax_valid;
	pixel_t     cmax;
	logic       ctrl_valid;
	pool_ctrl_t ctrl;

	//////////////////////////////////////////////////
	// Column builder
	//////////////////////////////////////////////////

	line_window u_line_window (
		.clk       (clk),
		.reset     (reset),
		.valid_in  (valid_in),
		.pxl_in    (pxl_in),
		.col_valid (col_valid),
		.col       (col)
	);

	//////////////////////////////////////////////////
	// Datapath and tracker side by side
	//////////////////////////////////////////////////

	column_max u_column_max (
		.clk        (clk),
		.reset      (reset),
		.col_valid  (col_valid),
		.col        (col),
		.mask_top   (mask_top),
		.cmax_valid (cmax_valid),
		.cmax       (cmax)
	);

	pool_position u_pool_position (
		.clk        (clk),
		.reset      (reset),
		.col_valid  (col_valid),
		.mask_top   (mask_top),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl)
	);

	// Horizontal max over three columns
	pool_combine u_pool_combine (
		.clk        (clk),
		.reset      (reset),
		.cmax_valid (cmax_valid),
		.cmax       (cmax),
		.ctrl_valid (ctrl_valid),
		.ctrl       (ctrl),
		.pxl_out    (pxl_out),
		.valid_out  (valid_out),
		.frame_done (frame_done)
	);

endmodule

//--- hdl/pool_combine.sv
`timescale 1ns/1ps

module pool_combine (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    cmax_valid,
	input  maxpool_pkg::pixel_t     cmax,
	input  logic                    ctrl_valid,
	input  maxpool_pkg::pool_ctrl_t ctrl,
	output maxpool_pkg::pixel_t     pxl_out,
	output logic                    valid_out,
	output logic                    frame_done
);

	import maxpool_pkg::*;

	// hist[0] is column c-1, hist[1] is column c-2
	pixel_t hist [2];

	logic   col_step;
	logic   fire;
	pixel_t left_eff;
	pixel_t near_max;
	pixel_t win_max;

	assign col_step = cmax_valid & ctrl_valid;
	assign fire     = col_step & ctrl.emit;

	// Column c-2 may still hold the end of the previous row
	always_comb begin
		left_eff = ctrl.mask_left ? '0 : hist[1];
		near_max = (cmax > hist[0]) ? cmax : hist[0];
		win_max  = (near_max > left_eff) ? near_max : left_eff;
	end

	//////////////////////////////////////////////////
	// Column history
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (col_step) begin
			hist[0] <= cmax;
			hist[1] <= hist[0];
		end
	end

	//////////////////////////////////////////////////
	// Pooled output
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			valid_out  <= 1'b0;
			frame_done <= 1'b0;
		end else begin
			valid_out  <= fire;
			frame_done <= fire & ctrl.last;
		end
	end

	always_ff @(posedge clk) begin
		if (fire) begin
			pxl_out <= win_max;
		end
	end

endmodule

//--- hdl/pool_position.sv
`timescale 1ns/1ps

module pool_position (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    col_valid,
	output logic                    mask_top,
	output logic                    ctrl_valid,
	output maxpool_pkg::pool_ctrl_t ctrl
);

	import maxpool_pkg::*;

	logic [COL_CNT_W-1:0] col_cnt;
	logic [ROW_CNT_W-1:0] row_cnt;

	logic col_end;
	logic row_end;

	pool_ctrl_t ctrl_next;

	assign col_end = (col_cnt == COL_CNT_W'(IMG_W - 1));
	assign row_end = (row_cnt == ROW_CNT_W'(IMG_H - 1));

	//////////////////////////////////////////////////
	// Position counters
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (col_valid) begin
			if (col_end) begin
				col_cnt <= '0;
				// Wraps to row 0 after the last row of the frame
				row_cnt <= row_end ? '0 : row_cnt + 1'b1;
			end else begin
				col_cnt <= col_cnt + 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// Window control
	//////////////////////////////////////////////////

	// Window rows r-2..r; only row 1 reaches above the image
	assign mask_top = (row_cnt == ROW_CNT_W'(1));

	always_comb begin
		ctrl_next.emit      = row_cnt[0] & col_cnt[0];
		ctrl_next.mask_top  = mask_top;
		ctrl_next.mask_left = (col_cnt == COL_CNT_W'(1));
		ctrl_next.last      = row_end & col_end;
	end

	// Registered to line up with cmax from column_max
	always_ff @(posedge clk) begin
		if (reset) begin
			ctrl_valid <= 1'b0;
		end else begin
			ctrl_valid <= col_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (col_valid) begin
			ctrl <= ctrl_next;
		end
	end

endmodule

//--- hdl/column_max.sv
`timescale 1ns/1ps

module column_max (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 col_valid,
	input  maxpool_pkg::column_t col,
	input  logic                 mask_top,
	output logic                 cmax_valid,
	output maxpool_pkg::pixel_t  cmax
);

	import maxpool_pkg::*;

	pixel_t top_eff;
	pixel_t upper_max;
	pixel_t col_peak;

	// Padding row contributes nothing; zero is neutral for unsigned max
	always_comb begin
		top_eff   = mask_top ? '0 : col.top;
		upper_max = (col.mid > top_eff) ? col.mid : top_eff;
		col_peak  = (col.bot > upper_max) ? col.bot : upper_max;
	end

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			cmax_valid <= 1'b0;
		end else begin
			cmax_valid <= col_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (col_valid) begin
			cmax <= col_peak;
		end
	end

endmodule

//--- hdl/line_window.sv
`timescale 1ns/1ps

module line_window (
	input  logic                 clk,
	input  logic                 reset,
	input  logic                 valid_in,
	input  maxpool_pkg::pixel_t  pxl_in,
	output logic                 col_valid,
	output maxpool_pkg::column_t col
);

	import maxpool_pkg::*;

	//////////////////////////////////////////////////
	// Row buffers
	//////////////////////////////////////////////////

	// row_prev holds the last IMG_W pixels, row_prev2 the IMG_W before them
	pixel_t row_prev  [IMG_W];
	pixel_t row_prev2 [IMG_W];

	// Oldest entries sit at the same column, one and two rows up
	pixel_t tap_mid;
	pixel_t tap_top;

	assign tap_mid = row_prev[IMG_W-1];
	assign tap_top = row_prev2[IMG_W-1];

	// Shift both buffers on every accepted pixel
	always_ff @(posedge clk) begin
		if (valid_in) begin
			row_prev[0]  <= pxl_in;
			row_prev2[0] <= tap_mid;
			for (int i = 1; i < IMG_W; i++) begin
				row_prev[i]  <= row_prev[i-1];
				row_prev2[i] <= row_prev2[i-1];
			end
		end
	end

	//////////////////////////////////////////////////
	// Column output
	//////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			col_valid <= 1'b0;
		end else begin
			col_valid <= valid_in;
		end
	end

	// Payload only, qualified by col_valid downstream
	always_ff @(posedge clk) begin
		if (valid_in) begin
			col.top <= tap_top;
			col.mid <= tap_mid;
			col.bot <= pxl_in;
		end
	end

endmodule

//--- hdl/maxpool_pkg.sv
package maxpool_pkg;

	//////////////////////////////////////////////////
	// Image geometry
	//////////////////////////////////////////////////

	localparam int DATA_W = 8;

	// Both dimensions must be even
	localparam int IMG_W = 8;
	localparam int IMG_H = 8;

	localparam int COL_CNT_W = $clog2(IMG_W);
	localparam int ROW_CNT_W = $clog2(IMG_H);

	// Stride 2 in both directions
	localparam int OUT_PER_FRAME = (IMG_W / 2) * (IMG_H / 2);

	//////////////////////////////////////////////////
	// Data and control types
	//////////////////////////////////////////////////

	typedef logic [DATA_W-1:0] pixel_t;

	// Rows r-2, r-1 and r at the current column
	typedef struct packed {
		pixel_t top;
		pixel_t mid;
		pixel_t bot;
	} column_t;

	// Per-column control from the position tracker
	typedef struct packed {
		logic emit;
		logic mask_top;
		logic mask_left;
		logic last;
	} pool_ctrl_t;

endpackage
